// File: verilog.f
rtl/rdma_rd_pkg.sv
rtl/sync_fifo.sv
rtl/rd_stream_mux.sv
rtl/rdma_rd_top.sv
verification/rdma_rd_chk.sv
verification/tb_rdma_rd.sv

// File: Bender.yml
package:
  name: rdma_rd

sources:
  - rtl/rdma_rd_pkg.sv
  - rtl/sync_fifo.sv
  - rtl/rd_stream_mux.sv
  - rtl/rdma_rd_top.sv
  - target: simulation
    files:
      - verification/rdma_rd_chk.sv
      - verification/tb_rdma_rd.sv

// File: verification/tb_rdma_rd.sv
/* Testbench for the read return path, LFSR stimulus on requests and both
   sources, back-pressure stretches and a watchdog */

`timescale 1ns/1ps

module tb_rdma_rd;

  import rdma_rd_pkg::*;

  localparam int N_REQ = 40;
  // Up to 64 beats per request, at most 4 cycles per beat
  localparam int WATCHDOG_NS = N_REQ * 64 * 4 * 100;

  logic  aclk;
  logic  aresetn;
  logic  rq_valid, rq_ready, sq_valid, sq_ready;
  logic  host_valid, host_ready, card_valid, card_ready;
  logic  out_valid, out_ready;
  req_t  rq, sq;
  beat_t host, card, out;

  // Random state and the requests issued so far
  logic [31:0]          lfsr = 32'h595f;
  logic [BLEN_BITS-1:0] req_len [N_REQ];
  logic                 req_strm [N_REQ];
  int                   n_iss = 0;
  int                   n_sq = 0;
  int                   n_out = 0;
  int                   n_beats = 0;
  int                   cyc = 0;

  // Source models, index 1 is host and 0 is card
  logic                 src_v [2] = '{1'b0, 1'b0};
  beat_t                src_b [2] = '{default: '0};
  int                   src_p [2] = '{0, 0};
  int                   src_n [2] = '{0, 0};
  logic [DATA_BITS-2:0] src_seq [2] = '{default: '0};

  rdma_rd_top dut_i (.*);

  bind rdma_rd_top rdma_rd_chk chk_i (.*);

  initial aclk = 1'b0;
  always #50 aclk = ~aclk;

  // Galois step, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  // Collect n bits, one LFSR step each
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus, one process so the LFSR order is fixed
  // --------------------------------------------------------------------------

  always @(posedge aclk) begin
    logic [31:0] r;
    req_t        nr;
    logic        rdy [2];
    if (aresetn) begin
      rdy[0] = card_ready;
      rdy[1] = host_ready;
      cyc++;
      n_out += int'(out_valid && out_ready);
      n_sq  += int'(sq_valid && sq_ready);
      // Next request once the previous one is taken
      if (!rq_valid || rq_ready) begin
        draw(1, r);
        if (n_iss < N_REQ && r[0]) begin
          draw(32, r);
          nr.vaddr = r;
          draw(7, r);
          nr.len  = r[6:1];
          nr.strm = r[0];
          req_len[n_iss]  = nr.len;
          req_strm[n_iss] = nr.strm;
          n_beats += int'(nr.len) + 1;
          n_iss++;
          rq       <= nr;
          rq_valid <= 1'b1;
        end else begin
          rq_valid <= 1'b0;
        end
      end
      for (int s = 0; s < 2; s++) begin
        if (src_v[s] && rdy[s]) begin
          src_v[s] = 1'b0;
          src_seq[s]++;
          src_n[s] = src_b[s].tlast ? 0 : src_n[s] + 1;
          src_p[s] = src_b[s].tlast ? src_p[s] + 1 : src_p[s];
        end
        // Skip requests meant for the other source
        while (src_p[s] < n_iss && req_strm[src_p[s]] != s[0]) begin
          src_p[s]++;
        end
        draw(2, r);
        if (!src_v[s] && src_p[s] < n_iss && r[1:0] != 2'b00) begin
          src_b[s].tdata = {s[0], src_seq[s]};
          src_b[s].tkeep = '1;
          src_b[s].tlast = (src_n[s] == int'(req_len[src_p[s]]));
          src_b[s].tid   = src_seq[s][ID_BITS-1:0];
          src_v[s] = 1'b1;
        end
      end
      host_valid <= src_v[1];
      host       <= src_b[1];
      card_valid <= src_v[0];
      card       <= src_b[0];
      // Back-pressure in alternating stretches
      draw(4, r);
      out_ready <= !cyc[7] || r[0];
      sq_ready  <= !cyc[8] || (r[3:1] == 3'b000);
    end
  end

  // --------------------------------------------------------------------------
  // Run control
  // --------------------------------------------------------------------------

  initial begin
    aresetn    <= 1'b0;
    rq_valid   <= 1'b0;
    rq         <= '0;
    sq_ready   <= 1'b0;
    host_valid <= 1'b0;
    host       <= '0;
    card_valid <= 1'b0;
    card       <= '0;
    out_ready  <= 1'b0;
    repeat (2) @(posedge aclk);
    aresetn <= 1'b1;
    // Every request forwarded and every beat delivered
    while (!(n_iss == N_REQ && n_sq == N_REQ && n_out == n_beats)) begin
      @(negedge aclk);
    end
    repeat (4) @(posedge aclk);
    @(negedge aclk);
    if (dut_i.chk_i.fails == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "Checker assertions failed during the run");
    end
  end

  // Stop at the first checker failure
  always @(dut_i.chk_i.fails) begin
    if (dut_i.chk_i.fails != 0) begin
      $display("TEST FAILED");
      $fatal(1, "A protocol assertion failed");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("TEST FAILED");
    $fatal(1, "Timeout, the requests did not drain before the watchdog expired");
  end

endmodule

// File: verification/rdma_rd_chk.sv
/* Bound checker for the read return path, reference request memory and
   protocol assertions */

`timescale 1ns/1ps

module rdma_rd_chk (
  input logic               aclk,
  input logic               aresetn,
  input logic               rq_valid,
  input logic               rq_ready,
  input rdma_rd_pkg::req_t  rq,
  input logic               sq_valid,
  input logic               sq_ready,
  input rdma_rd_pkg::req_t  sq,
  input logic               host_valid,
  input logic               host_ready,
  input logic               card_valid,
  input logic               card_ready,
  input logic               out_valid,
  input logic               out_ready,
  input rdma_rd_pkg::beat_t out
);

  import rdma_rd_pkg::*;

  // Accepted requests in order, one read pointer per consumer
  req_t       req_mem [64];
  logic [5:0] wr_p;
  logic [5:0] sq_p;
  logic [5:0] in_p;
  logic [5:0] out_p;

  // Beat position in the current request, source side and output side
  logic [BLEN_BITS-1:0] in_cnt;
  logic [BLEN_BITS-1:0] out_cnt;

  // Next sequence number per source, indexed by strm
  logic [DATA_BITS-2:0] seq_exp [2];

  logic        seen_rq;
  int unsigned fails = 0;

  // Heads seen by each consumer
  req_t                 sq_head;
  req_t                 in_req;
  req_t                 out_req;
  logic [DATA_BITS-1:0] out_exp;
  logic [ID_BITS-1:0]   tid_exp;
  logic                 src_hs;
  logic                 out_hs;

  assign sq_head = req_mem[sq_p];
  assign in_req  = req_mem[in_p];
  assign out_req = req_mem[out_p];
  // Source tag on top, that source's sequence below
  assign out_exp = {out_req.strm, seq_exp[out_req.strm]};
  // Sources put the low sequence bits on tid
  assign tid_exp = seq_exp[out_req.strm][ID_BITS-1:0];
  assign src_hs  = (host_valid && host_ready) || (card_valid && card_ready);
  assign out_hs  = out_valid && out_ready;

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      {wr_p, sq_p, in_p, out_p} <= '0;
      {in_cnt, out_cnt, seen_rq} <= '0;
      seq_exp <= '{default: '0};
    end else begin
      if (rq_valid && rq_ready) begin
        req_mem[wr_p] <= rq;
        wr_p          <= wr_p + 6'd1;
        seen_rq       <= 1'b1;
      end
      if (sq_valid && sq_ready) begin
        sq_p <= sq_p + 6'd1;
      end
      // Source side moves on after len+1 beats
      if (src_hs) begin
        in_cnt <= (in_cnt == in_req.len) ? '0 : in_cnt + 1'b1;
        in_p   <= (in_cnt == in_req.len) ? in_p + 6'd1 : in_p;
      end
      if (out_hs) begin
        seq_exp[out_req.strm] <= seq_exp[out_req.strm] + 1'b1;
        out_cnt <= (out_cnt == out_req.len) ? '0 : out_cnt + 1'b1;
        out_p   <= (out_cnt == out_req.len) ? out_p + 6'd1 : out_p;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------

  // Both outputs quiet until the first request
  a_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
    !seen_rq |-> !sq_valid && !out_valid)
    else begin
      fails++;
      $error("Fail reset_quiet expected 0 0 actual %b %b", sq_valid, out_valid);
    end

  a_sq_order: assert property (@(posedge aclk) disable iff (!aresetn)
    sq_valid && sq_ready |-> sq == sq_head)
    else begin
      fails++;
      $error("Fail sq_order expected %h actual %h", sq_head, sq);
    end

  // Tag, sequence, tlast, tkeep and tid of every delivered beat
  a_out_beat: assert property (@(posedge aclk) disable iff (!aresetn)
    out_hs |-> out.tdata == out_exp && out.tlast == (out_cnt == out_req.len) &&
      out.tkeep == '1 && out.tid == tid_exp)
    else begin
      fails++;
      $error("Fail out_beat expected %h/%h/%b/%h actual %h/%h/%b/%h",
             out_exp, {KEEP_BITS{1'b1}}, out_cnt == out_req.len, tid_exp,
             out.tdata, out.tkeep, out.tlast, out.tid);
    end

  a_out_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && !out_ready |=> out_valid && $stable(out))
    else begin
      fails++;
      $error("Output beat changed or was withdrawn while out_ready was low");
    end

  // Only the selected source of a running request sees ready
  a_ready_sel: assert property (@(posedge aclk) disable iff (!aresetn)
    host_ready || card_ready |->
      (in_p != wr_p) && (host_ready != card_ready) && (host_ready == in_req.strm))
    else begin
      fails++;
      $error("Fail ready_sel expected host=%b actual host=%b card=%b",
             in_req.strm, host_ready, card_ready);
    end

endmodule

// File: rtl/rdma_rd_top.sv
/* Read-data return path top level, request mux with send-queue and
   output data FIFOs */

`timescale 1ns/1ps

module rdma_rd_top #(
  // Send-queue entries
  parameter int SQ_DEPTH   = 4,
  // Output data beats buffered
  parameter int DATA_DEPTH = 16
) (
  input  logic                aclk,
  input  logic                aresetn,

  // Requests in
  input  logic                rq_valid,
  output logic                rq_ready,
  input  rdma_rd_pkg::req_t   rq,

  // Send-queue out
  output logic                sq_valid,
  input  logic                sq_ready,
  output rdma_rd_pkg::req_t   sq,

  // Data sources
  input  logic                host_valid,
  output logic                host_ready,
  input  rdma_rd_pkg::beat_t  host,
  input  logic                card_valid,
  output logic                card_ready,
  input  rdma_rd_pkg::beat_t  card,

  // Merged data out
  output logic                out_valid,
  input  logic                out_ready,
  output rdma_rd_pkg::beat_t  out
);

  import rdma_rd_pkg::*;

  // Mux to send-queue FIFO
  logic  sq_push_valid;
  logic  sq_push_ready;
  req_t  sq_push;

  // Mux to data FIFO
  logic  dq_push_valid;
  logic  dq_push_ready;
  beat_t dq_push;

  // Request FSM and source steering
  rd_stream_mux mux_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .rq_valid      (rq_valid),
    .rq_ready      (rq_ready),
    .rq            (rq),
    .sq_push_valid (sq_push_valid),
    .sq_push_ready (sq_push_ready),
    .sq_push       (sq_push),
    .host_valid    (host_valid),
    .host_ready    (host_ready),
    .host          (host),
    .card_valid    (card_valid),
    .card_ready    (card_ready),
    .card          (card),
    .dq_push_valid (dq_push_valid),
    .dq_push_ready (dq_push_ready),
    .dq_push       (dq_push)
  );

  // Accepted requests on their way out
  sync_fifo #(
    .T     (req_t),
    .DEPTH (SQ_DEPTH)
  ) sq_fifo_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .push_valid (sq_push_valid),
    .push_ready (sq_push_ready),
    .push       (sq_push),
    .pop_valid  (sq_valid),
    .pop_ready  (sq_ready),
    .pop        (sq)
  );

  // Steered beats, absorbs output back-pressure
  sync_fifo #(
    .T     (beat_t),
    .DEPTH (DATA_DEPTH)
  ) data_fifo_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .push_valid (dq_push_valid),
    .push_ready (dq_push_ready),
    .push       (dq_push),
    .pop_valid  (out_valid),
    .pop_ready  (out_ready),
    .pop        (out)
  );

endmodule

// File: rtl/rd_stream_mux.sv
/* Read request FSM with beat counter, steering host or card beats onto
   one stream and forwarding each accepted request to the send-queue */

`timescale 1ns/1ps

module rd_stream_mux (
  input  logic                aclk,
  input  logic                aresetn,

  // Incoming read requests
  input  logic                rq_valid,
  output logic                rq_ready,
  input  rdma_rd_pkg::req_t   rq,

  // Send-queue FIFO write side
  output logic                sq_push_valid,
  input  logic                sq_push_ready,
  output rdma_rd_pkg::req_t   sq_push,

  // Host memory data source
  input  logic                host_valid,
  output logic                host_ready,
  input  rdma_rd_pkg::beat_t  host,

  // Card memory data source
  input  logic                card_valid,
  output logic                card_ready,
  input  rdma_rd_pkg::beat_t  card,

  // Data FIFO write side
  output logic                dq_push_valid,
  input  logic                dq_push_ready,
  output rdma_rd_pkg::beat_t  dq_push
);

  import rdma_rd_pkg::*;

  // --------------------------------------------------------------------------
  // State
  // --------------------------------------------------------------------------

  // Idle waits for a request, mux moves its beats
  typedef enum logic {
    ST_IDLE,
    ST_MUX
  } state_t;

  state_t state_q;
  state_t state_d;

  // Beats still to move after the current one
  logic [BLEN_BITS-1:0] cnt_q;
  logic [BLEN_BITS-1:0] cnt_d;

  // Registered source select, STRM_HOST or STRM_CARD
  logic sel_q;
  logic sel_d;

  // Beat accepted by the data FIFO
  logic beat_hs;

  // Last beat of the current request accepted
  logic tr_done;

  // Request taken this cycle
  logic take_rq;

  // --------------------------------------------------------------------------
  // Request side
  // --------------------------------------------------------------------------

  // End of transfer on the accepted beat with the counter at zero
  assign beat_hs = dq_push_valid && dq_push_ready;
  assign tr_done = (state_q == ST_MUX) && (cnt_q == '0) && beat_hs;

  // New request when idle or on the final beat, only if sq has room
  assign take_rq = rq_valid && sq_push_ready && ((state_q == ST_IDLE) || tr_done);

  // Accept and forward in the same cycle
  assign rq_ready      = take_rq;
  assign sq_push_valid = take_rq;
  assign sq_push       = rq;

  // --------------------------------------------------------------------------
  // Stream steering
  // --------------------------------------------------------------------------

  always_comb begin
    // Path closed unless a transfer is running
    dq_push_valid = 1'b0;
    dq_push       = '0;
    host_ready    = 1'b0;
    card_ready    = 1'b0;

    if (state_q == ST_MUX) begin
      if (sel_q == STRM_HOST) begin
        dq_push_valid = host_valid;
        dq_push       = host;
        host_ready    = dq_push_ready;
      end else begin
        dq_push_valid = card_valid;
        dq_push       = card;
        card_ready    = dq_push_ready;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Next state, counter and select
  // --------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    sel_d   = sel_q;

    if (take_rq) begin
      // Load from the request, back to back on a final beat
      state_d = ST_MUX;
      cnt_d   = rq.len;
      sel_d   = rq.strm;
    end else if (tr_done) begin
      // Done and nothing to take
      state_d = ST_IDLE;
    end else if ((state_q == ST_MUX) && beat_hs) begin
      // One beat fewer to go
      cnt_d = cnt_q - BLEN_BITS'(1);
    end
  end

  // --------------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      sel_q   <= STRM_CARD;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      sel_q   <= sel_d;
    end
  end

endmodule

// File: rtl/sync_fifo.sv
/* Synchronous valid/ready FIFO, payload type and depth set by parameters */

`timescale 1ns/1ps

module sync_fifo #(
  // Payload carried through the FIFO
  parameter type T     = logic [7:0],
  // Number of entries, power of two and at least 2
  parameter int  DEPTH = 4
) (
  input  logic aclk,
  input  logic aresetn,

  // Write side
  input  logic push_valid,
  output logic push_ready,
  input  T     push,

  // Read side
  output logic pop_valid,
  input  logic pop_ready,
  output T     pop
);

  // --------------------------------------------------------------------------
  // Sizing
  // --------------------------------------------------------------------------

  // Pointer width, wraps on its own for a power of two depth
  localparam int PTR_BITS = $clog2(DEPTH);

  // Occupancy needs one more code than pointers (0 .. DEPTH)
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  // --------------------------------------------------------------------------
  // Storage and state
  // --------------------------------------------------------------------------

  // Entry storage, no reset
  T mem [DEPTH];

  // Next slot to write
  logic [PTR_BITS-1:0] wr_ptr;

  // Slot shown at the output
  logic [PTR_BITS-1:0] rd_ptr;

  // Entries currently held
  logic [CNT_BITS-1:0] count;

  // Status
  logic full;
  logic empty;

  // Handshakes on either side
  logic do_push;
  logic do_pop;

  // --------------------------------------------------------------------------
  // Status and handshakes
  // --------------------------------------------------------------------------

  assign full  = (count == CNT_BITS'(DEPTH));
  assign empty = (count == '0);

  // Output validity straight from the occupancy register
  assign pop_valid = !empty;

  // Head entry, visible the cycle after it was written
  assign pop = mem[rd_ptr];

  // Full FIFO still takes a write when the head leaves this cycle
  assign push_ready = !full || pop_ready;

  assign do_push = push_valid && push_ready;
  assign do_pop  = pop_valid && pop_ready;

  // --------------------------------------------------------------------------
  // Storage write
  // --------------------------------------------------------------------------

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push;
    end
  end

  // --------------------------------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------------------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Advance write pointer on every accepted item
      if (do_push) begin
        wr_ptr <= wr_ptr + PTR_BITS'(1);
      end

      // Advance read pointer on every taken item
      if (do_pop) begin
        rd_ptr <= rd_ptr + PTR_BITS'(1);
      end

      // Occupancy only moves when one side is idle
      case ({do_push, do_pop})
        2'b10: begin
          count <= count + CNT_BITS'(1);
        end
        2'b01: begin
          count <= count - CNT_BITS'(1);
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

// File: rtl/rdma_rd_pkg.sv
/* Shared widths, request and stream beat types for the RDMA read
   return path */

package rdma_rd_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------

  // Data beat width
  parameter int DATA_BITS = 64;

  // One byte enable per data byte
  parameter int KEEP_BITS = DATA_BITS / 8;

  // Stream id, passed through untouched
  parameter int ID_BITS = 4;

  // Beat count field, holds beats minus one
  parameter int BLEN_BITS = 6;

  // Request virtual address
  parameter int ADDR_BITS = 32;

  // --------------------------------------------------------------------------
  // Source encoding of the strm field
  // --------------------------------------------------------------------------

  // Data comes from host memory
  parameter logic STRM_HOST = 1'b1;

  // Data comes from card memory
  parameter logic STRM_CARD = 1'b0;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  // Read request as seen on rq and forwarded on sq
  typedef struct packed {
    logic [ADDR_BITS-1:0] vaddr;
    // Number of beats minus one
    logic [BLEN_BITS-1:0] len;
    // Source select, see STRM_HOST / STRM_CARD
    logic                 strm;
  } req_t;

  // One beat of a data stream
  typedef struct packed {
    logic [DATA_BITS-1:0] tdata;
    logic [KEEP_BITS-1:0] tkeep;
    // Passed through, not used for counting
    logic                 tlast;
    logic [ID_BITS-1:0]   tid;
  } beat_t;

endpackage
